//--- rv_exec.f
+incdir+rtl
rtl/rv_exec_pkg.sv
rtl/idex_if.sv
rtl/instr_decode.sv
rtl/idex_regs.sv
rtl/exec_stage.sv
rtl/rv_exec_top.sv
sim/rv_exec_props.sv
sim/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

export_include_dirs:
  - rtl

sources:
  - rtl/rv_exec_pkg.sv
  - rtl/idex_if.sv
  - rtl/instr_decode.sv
  - rtl/idex_regs.sv
  - rtl/exec_stage.sv
  - rtl/rv_exec_top.sv
  - target: simulation
    files:
      - sim/rv_exec_props.sv
      - sim/rv_exec_tb.sv

//--- sim/rv_exec_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_exec_tb;

    localparam int MAX_CYCLES = 2000;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic                       clk;
    logic                       rst;
    logic [`RV_XLEN-1:0]        instruction;
    logic [`RV_XLEN-1:0]        pc;
    logic                       wb_en;
    logic [`RV_REG_ADDR_W-1:0]  wb_rd;
    logic [`RV_XLEN-1:0]        wb_data;
    logic                       flush;
    logic                       stall;
    logic [`RV_XLEN-1:0]        ex_result;
    logic [`RV_REG_ADDR_W-1:0]  ex_rd;
    logic                       ex_write_enable;
    logic                       ex_mem_read;
    logic                       ex_mem_write;
    logic                       ex_mem_to_reg;
    logic [`RV_XLEN-1:0]        ex_store_data;
    logic                       ex_branch_taken;
    logic [`RV_XLEN-1:0]        ex_branch_target;
    logic [105:0]               all_outputs;

    // Register contents as written through the write-back port
    logic [`RV_XLEN-1:0]        rf [0:`RV_NUM_REGS-1];

    int cycle_count = 0;
    int errors = 0;
    int errors_at_start = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    rv_exec_top DUT (.*);

    assign all_outputs = {ex_result, ex_rd, ex_write_enable, ex_mem_read, ex_mem_write,
                          ex_mem_to_reg, ex_store_data, ex_branch_taken, ex_branch_target};

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // alt selects SUB for add and the arithmetic right shift
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_write(input string what, input logic [31:0] exp_res,
                               input logic [4:0] exp_rd, input logic exp_we);
        expect_eq({what, " result"}, ex_result, exp_res);
        expect_eq({what, " rd"}, ex_rd, exp_rd);
        expect_eq({what, " write_enable"}, ex_write_enable, exp_we);
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
        @(posedge clk);
        wb_en   <= 1'b1;
        wb_rd   <= idx;
        wb_data <= val;
        @(posedge clk);
        wb_en <= 1'b0;
        if (idx != 0) begin
            rf[idx] = val;
        end
    endtask

    // Outputs are valid just after the second edge following the drive
    task automatic issue(input logic [31:0] instr, input logic [31:0] pc_val);
        @(posedge clk);
        instruction <= instr;
        pc          <= pc_val;
        @(posedge clk);
        instruction <= `RV_NOP;
        @(posedge clk);
        #1;
    endtask

    task automatic reg_alu_ops();
        logic [2:0] f3s [0:9] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5, 3'd5, 3'd2, 3'd3};
        logic       alts [0:9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        string      names [0:9] = '{"ADD", "SUB", "AND", "OR", "XOR",
                                    "SLL", "SRL", "SRA", "SLT", "SLTU"};
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        int         k;
        start_test();
        for (int i = 1; i <= 8; i++) begin
            write_reg(5'(i), $urandom);
        end
        @(posedge clk);
        // Last pass repeats ADD with rd = x0
        for (int i = 0; i < 11; i++) begin
            k   = i % 10;
            rs1 = 5'(1 + i % 4);
            rs2 = 5'(5 + i % 4);
            rd  = (i == 10) ? 5'd0 : 5'(20 + i);
            issue(r_type(alts[k] ? 7'b0100000 : 7'b0, rs2, rs1, f3s[k], rd), 32'h100);
            check_write(names[k], alu_model(f3s[k], alts[k], rf[rs1], rf[rs2]), rd, rd != 0);
        end
        finish_test("register-register ALU");
    endtask

    task automatic imm_forms();
        logic [11:0] imm;
        logic [19:0] upper;
        logic [4:0]  shamt;
        logic [31:0] pc_val;
        start_test();
        imm = 12'($urandom);
        issue(i_type(imm, 5'd1, 3'b000, 5'd10, OPC_OP_IMM), 32'h200);
        check_write("ADDI", rf[1] + sext12(imm), 5'd10, 1'b1);
        imm = 12'($urandom);
        issue(i_type(imm, 5'd2, 3'b010, 5'd11, OPC_OP_IMM), 32'h204);
        check_write("SLTI", ($signed(rf[2]) < $signed(sext12(imm))) ? 32'd1 : 32'd0,
                    5'd11, 1'b1);
        imm = 12'($urandom);
        issue(i_type(imm, 5'd3, 3'b100, 5'd12, OPC_OP_IMM), 32'h208);
        check_write("XORI", rf[3] ^ sext12(imm), 5'd12, 1'b1);
        shamt = 5'($urandom);
        issue(i_type({7'b0100000, shamt}, 5'd4, 3'b101, 5'd13, OPC_OP_IMM), 32'h20c);
        check_write("SRAI", $unsigned($signed(rf[4]) >>> shamt), 5'd13, 1'b1);
        upper = 20'($urandom);
        issue(u_type(upper, 5'd14, OPC_LUI), 32'h210);
        check_write("LUI", {upper, 12'b0}, 5'd14, 1'b1);
        upper  = 20'($urandom);
        pc_val = $urandom & 32'hffff_fffc;
        issue(u_type(upper, 5'd15, OPC_AUIPC), pc_val);
        check_write("AUIPC", pc_val + {upper, 12'b0}, 5'd15, 1'b1);
        finish_test("immediate forms");
    endtask

    task automatic load_store();
        logic [11:0] off;
        start_test();
        off = 12'($urandom);
        issue(i_type(off, 5'd5, 3'b010, 5'd16, OPC_LOAD), 32'h300);
        check_write("LW", rf[5] + sext12(off), 5'd16, 1'b1);
        expect_eq("LW mem_read", ex_mem_read, 1'b1);
        expect_eq("LW mem_to_reg", ex_mem_to_reg, 1'b1);
        expect_eq("LW mem_write", ex_mem_write, 1'b0);
        off = 12'($urandom);
        issue(s_type(off, 5'd6, 5'd7, 3'b010), 32'h304);
        expect_eq("SW address", ex_result, rf[7] + sext12(off));
        expect_eq("SW mem_write", ex_mem_write, 1'b1);
        expect_eq("SW mem_read", ex_mem_read, 1'b0);
        expect_eq("SW store data", ex_store_data, rf[6]);
        expect_eq("SW write_enable", ex_write_enable, 1'b0);
        finish_test("loads and stores");
    endtask

    task automatic branches();
        // Equal, less in both senses, greater in both, and the two mixed pairs
        logic [4:0]  lhs [0:4] = '{5'd10, 5'd10, 5'd13, 5'd11, 5'd10};
        logic [4:0]  rhs [0:4] = '{5'd12, 5'd13, 5'd10, 5'd10, 5'd11};
        logic [2:0]  conds [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        logic [12:0] off;
        logic [31:0] pc_val;
        start_test();
        write_reg(5'd10, 32'h0000_0005);
        write_reg(5'd11, 32'hffff_fff0);
        write_reg(5'd12, 32'h0000_0005);
        write_reg(5'd13, 32'h0000_0100);
        @(posedge clk);
        for (int p = 0; p < 5; p++) begin
            for (int c = 0; c < 6; c++) begin
                off    = 13'($urandom) & 13'h1ffe;
                pc_val = $urandom & 32'hffff_fffc;
                issue(b_type(off, rhs[p], lhs[p], conds[c]), pc_val);
                expect_eq($sformatf("branch f3=%0d pair %0d taken", conds[c], p),
                          ex_branch_taken, branch_model(conds[c], rf[lhs[p]], rf[rhs[p]]));
                expect_eq($sformatf("branch f3=%0d pair %0d target", conds[c], p),
                          ex_branch_target, pc_val + {{19{off[12]}}, off});
                expect_eq("branch result", ex_result, 32'd0);
                expect_eq("branch write_enable", ex_write_enable, 1'b0);
            end
        end
        finish_test("branches");
    endtask

    task automatic stall_hold();
        logic [105:0] held;
        start_test();
        @(posedge clk);
        instruction <= r_type(7'b0, 5'd2, 5'd1, 3'b000, 5'd20);
        pc          <= 32'h500;
        @(posedge clk);
        stall       <= 1'b1;
        instruction <= $urandom;
        pc          <= $urandom;
        #1;
        held = all_outputs;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            if (k == 2) begin
                stall       <= 1'b0;
                instruction <= r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd21);
                pc          <= 32'h504;
            end else begin
                instruction <= $urandom;
                pc          <= $urandom;
            end
            #1;
            if (all_outputs !== held) begin
                $display("error %0t: outputs changed while stalled", $time);
                errors++;
            end
        end
        @(posedge clk);
        instruction <= `RV_NOP;
        #1;
        check_write("ADD held by stall", rf[1] + rf[2], 5'd20, 1'b1);
        @(posedge clk);
        #1;
        check_write("SUB after stall", rf[1] - rf[2], 5'd21, 1'b1);
        finish_test("stall");
    endtask

    task automatic flush_and_reset();
        start_test();
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        #1;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            rf[i] = '0;
        end
        if (all_outputs !== '0) begin
            $display("error %0t: outputs are not all zero after reset", $time);
            errors++;
        end
        write_reg(5'd1, $urandom);
        write_reg(5'd2, $urandom);
        // Load issued together with flush becomes a bubble
        @(posedge clk);
        instruction <= i_type(12'h010, 5'd1, 3'b010, 5'd22, OPC_LOAD);
        pc          <= 32'h600;
        flush       <= 1'b1;
        @(posedge clk);
        instruction <= `RV_NOP;
        flush       <= 1'b0;
        @(posedge clk);
        #1;
        expect_eq("flush write_enable", ex_write_enable, 1'b0);
        expect_eq("flush mem_read", ex_mem_read, 1'b0);
        expect_eq("flush mem_write", ex_mem_write, 1'b0);
        expect_eq("flush branch_taken", ex_branch_taken, 1'b0);
        expect_eq("flush result", ex_result, 32'd0);
        issue(r_type(7'b0, 5'd2, 5'd1, 3'b100, 5'd23), 32'h604);
        check_write("XOR after flush", rf[1] ^ rf[2], 5'd23, 1'b1);
        finish_test("flush and reset");
    endtask

    initial begin
        void'($urandom(63296));
        rst         = 1'b1;
        instruction = `RV_NOP;
        pc          = '0;
        wb_en       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        flush       = 1'b0;
        stall       = 1'b0;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            rf[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        reg_alu_ops();
        imm_forms();
        load_store();
        branches();
        stall_hold();
        flush_and_reset();
        $display("Summary: %0d tests passed, %0d failed, %0d errors, %0d assertion failures",
                 tests_passed, tests_failed, errors, DUT.u_idex.u_idex_props.fail_count);
        if (tests_failed == 0 && DUT.u_idex.u_idex_props.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/rv_exec_props.sv
`default_nettype none
`timescale 1ns/1ps

module idex_props (
    input wire         clk,
    input wire         rst,
    input wire         flush,
    input wire         stall,
    input wire [203:0] in_bundle,
    input wire [203:0] out_bundle,
    input wire         out_write_enable,
    input wire         out_mem_read,
    input wire         out_mem_write
);

    // Number of failed assertions
    int fail_count = 0;

    // A bubble has no side effects
    clear_on_flush: assert property (@(posedge clk) (rst || flush) |=>
            (!out_write_enable && !out_mem_read && !out_mem_write))
        else begin
            $error("ID/EX control not cleared after flush or reset");
            fail_count++;
        end

    hold_on_stall: assert property (@(posedge clk) (!rst && !flush && stall) |=>
            $stable(out_bundle))
        else begin
            $error("ID/EX contents changed under stall");
            fail_count++;
        end

    capture: assert property (@(posedge clk) (!rst && !flush && !stall) |=>
            (out_bundle == $past(in_bundle)))
        else begin
            $error("ID/EX did not capture the decode bundle");
            fail_count++;
        end

endmodule

bind idex_regs idex_props u_idex_props (
    .clk              (clk),
    .rst              (rst),
    .flush            (flush),
    .stall            (stall),
    .in_bundle        ({id_in.instruction, id_in.pc, id_in.immediate, id_in.rs1, id_in.rs2,
                        id_in.data_rs1, id_in.data_rs2, id_in.alu_src, id_in.alu_op,
                        id_in.funct7, id_in.funct3, id_in.opcode, id_in.instr_type,
                        id_in.rd, id_in.mem_write, id_in.mem_read, id_in.branch_inst,
                        id_in.mem_to_reg, id_in.write_enable}),
    .out_bundle       ({ex_out.instruction, ex_out.pc, ex_out.immediate, ex_out.rs1,
                        ex_out.rs2, ex_out.data_rs1, ex_out.data_rs2, ex_out.alu_src,
                        ex_out.alu_op, ex_out.funct7, ex_out.funct3, ex_out.opcode,
                        ex_out.instr_type, ex_out.rd, ex_out.mem_write, ex_out.mem_read,
                        ex_out.branch_inst, ex_out.mem_to_reg, ex_out.write_enable}),
    .out_write_enable (ex_out.write_enable),
    .out_mem_read     (ex_out.mem_read),
    .out_mem_write    (ex_out.mem_write)
);

`default_nettype wire

//--- rtl/rv_exec_top.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_exec_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [`RV_XLEN-1:0]         instruction,
    input  wire [`RV_XLEN-1:0]         pc,
    input  wire                        wb_en,
    input  wire [`RV_REG_ADDR_W-1:0]   wb_rd,
    input  wire [`RV_XLEN-1:0]         wb_data,
    input  wire                        flush,
    input  wire                        stall,
    output logic [`RV_XLEN-1:0]        ex_result,
    output logic [`RV_REG_ADDR_W-1:0]  ex_rd,
    output logic                       ex_write_enable,
    output logic                       ex_mem_read,
    output logic                       ex_mem_write,
    output logic                       ex_mem_to_reg,
    output logic [`RV_XLEN-1:0]        ex_store_data,
    output logic                       ex_branch_taken,
    output logic [`RV_XLEN-1:0]        ex_branch_target
);

    // Decode to ID/EX, then ID/EX to execute
    idex_if id_bus ();
    idex_if ex_bus ();

    instr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .id_out      (id_bus.src)
    );

    idex_regs u_idex (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .stall  (stall),
        .id_in  (id_bus.dst),
        .ex_out (ex_bus.src)
    );

    exec_stage u_exec (
        .clk              (clk),
        .rst              (rst),
        .stall            (stall),
        .ex_in            (ex_bus.dst),
        .ex_result        (ex_result),
        .ex_rd            (ex_rd),
        .ex_write_enable  (ex_write_enable),
        .ex_mem_read      (ex_mem_read),
        .ex_mem_write     (ex_mem_write),
        .ex_mem_to_reg    (ex_mem_to_reg),
        .ex_store_data    (ex_store_data),
        .ex_branch_taken  (ex_branch_taken),
        .ex_branch_target (ex_branch_target)
    );

endmodule

`default_nettype wire

//--- rtl/exec_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module exec_stage (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        stall,
    idex_if.dst                        ex_in,
    output logic [`RV_XLEN-1:0]        ex_result,
    output logic [`RV_REG_ADDR_W-1:0]  ex_rd,
    output logic                       ex_write_enable,
    output logic                       ex_mem_read,
    output logic                       ex_mem_write,
    output logic                       ex_mem_to_reg,
    output logic [`RV_XLEN-1:0]        ex_store_data,
    output logic                       ex_branch_taken,
    output logic [`RV_XLEN-1:0]        ex_branch_target
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] result_d;
    logic                cond;

    // AUIPC adds to the pc, everything else to rs1
    assign op_a = (ex_in.opcode == rv_exec_pkg::OPC_AUIPC) ? ex_in.pc : ex_in.data_rs1;
    assign op_b = ex_in.alu_src ? ex_in.immediate : ex_in.data_rs2;

    always_comb begin
        case (rv_exec_pkg::alu_f3_e'(ex_in.funct3))
            rv_exec_pkg::F3_ADD: begin
                // SUB only exists in register form
                if ((ex_in.alu_op == rv_exec_pkg::ALU_REG) && ex_in.funct7[5]) begin
                    alu_res = op_a - op_b;
                end else begin
                    alu_res = op_a + op_b;
                end
            end
            rv_exec_pkg::F3_SLL:  alu_res = op_a << op_b[4:0];
            rv_exec_pkg::F3_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_exec_pkg::F3_SLTU: alu_res = {31'b0, op_a < op_b};
            rv_exec_pkg::F3_XOR:  alu_res = op_a ^ op_b;
            rv_exec_pkg::F3_SR: begin
                if (ex_in.funct7[5]) begin
                    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
                end else begin
                    alu_res = op_a >> op_b[4:0];
                end
            end
            rv_exec_pkg::F3_OR:   alu_res = op_a | op_b;
            default:              alu_res = op_a & op_b;
        endcase
    end

    // Branch compare on rs1 and rs2
    always_comb begin
        case (rv_exec_pkg::br_f3_e'(ex_in.funct3))
            rv_exec_pkg::F3_BEQ:  cond = ex_in.data_rs1 == ex_in.data_rs2;
            rv_exec_pkg::F3_BNE:  cond = ex_in.data_rs1 != ex_in.data_rs2;
            rv_exec_pkg::F3_BLT:  cond = $signed(ex_in.data_rs1) < $signed(ex_in.data_rs2);
            rv_exec_pkg::F3_BGE:  cond = $signed(ex_in.data_rs1) >= $signed(ex_in.data_rs2);
            rv_exec_pkg::F3_BLTU: cond = ex_in.data_rs1 < ex_in.data_rs2;
            rv_exec_pkg::F3_BGEU: cond = ex_in.data_rs1 >= ex_in.data_rs2;
            default:              cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_in.alu_op)
            rv_exec_pkg::ALU_REG,
            rv_exec_pkg::ALU_IMM: result_d = alu_res;
            rv_exec_pkg::ALU_ADD: result_d = op_a + ex_in.immediate;
            rv_exec_pkg::ALU_LUI: result_d = ex_in.immediate;
            default:              result_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_result        <= '0;
            ex_rd            <= '0;
            ex_write_enable  <= 1'b0;
            ex_mem_read      <= 1'b0;
            ex_mem_write     <= 1'b0;
            ex_mem_to_reg    <= 1'b0;
            ex_store_data    <= '0;
            ex_branch_taken  <= 1'b0;
            ex_branch_target <= '0;
        end else if (!stall) begin
            ex_result        <= result_d;
            ex_rd            <= ex_in.rd;
            ex_write_enable  <= ex_in.write_enable;
            ex_mem_read      <= ex_in.mem_read;
            ex_mem_write     <= ex_in.mem_write;
            ex_mem_to_reg    <= ex_in.mem_to_reg;
            ex_store_data    <= ex_in.data_rs2;
            ex_branch_taken  <= ex_in.branch_inst && cond;
            ex_branch_target <= ex_in.pc + ex_in.immediate;
        end
    end

endmodule

`default_nettype wire

//--- rtl/idex_regs.sv
`default_nettype none
`timescale 1ns/1ps

module idex_regs (
    input  wire  clk,
    input  wire  rst,
    input  wire  flush,
    input  wire  stall,
    idex_if.dst  id_in,
    idex_if.src  ex_out
);

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_out.instruction  <= '0;
            ex_out.pc           <= '0;
            ex_out.immediate    <= '0;
            ex_out.rs1          <= '0;
            ex_out.rs2          <= '0;
            ex_out.data_rs1     <= '0;
            ex_out.data_rs2     <= '0;
            ex_out.alu_src      <= 1'b0;
            ex_out.alu_op       <= rv_exec_pkg::ALU_ADD;
            ex_out.funct7       <= '0;
            ex_out.funct3       <= '0;
            ex_out.opcode       <= rv_exec_pkg::opcode_e'('0);
            ex_out.instr_type   <= rv_exec_pkg::TYPE_R;
            ex_out.rd           <= '0;
            ex_out.mem_write    <= 1'b0;
            ex_out.mem_read     <= 1'b0;
            ex_out.branch_inst  <= 1'b0;
            ex_out.mem_to_reg   <= 1'b0;
            ex_out.write_enable <= 1'b0;
        end else if (!stall) begin
            ex_out.instruction  <= id_in.instruction;
            ex_out.pc           <= id_in.pc;
            ex_out.immediate    <= id_in.immediate;
            ex_out.rs1          <= id_in.rs1;
            ex_out.rs2          <= id_in.rs2;
            ex_out.data_rs1     <= id_in.data_rs1;
            ex_out.data_rs2     <= id_in.data_rs2;
            ex_out.alu_src      <= id_in.alu_src;
            ex_out.alu_op       <= id_in.alu_op;
            ex_out.funct7       <= id_in.funct7;
            ex_out.funct3       <= id_in.funct3;
            ex_out.opcode       <= id_in.opcode;
            ex_out.instr_type   <= id_in.instr_type;
            ex_out.rd           <= id_in.rd;
            ex_out.mem_write    <= id_in.mem_write;
            ex_out.mem_read     <= id_in.mem_read;
            ex_out.branch_inst  <= id_in.branch_inst;
            ex_out.mem_to_reg   <= id_in.mem_to_reg;
            ex_out.write_enable <= id_in.write_enable;
        end
    end

endmodule

`default_nettype wire

//--- rtl/instr_decode.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module instr_decode (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [`RV_XLEN-1:0]         instruction,
    input  wire [`RV_XLEN-1:0]         pc,
    input  wire                        wb_en,
    input  wire [`RV_REG_ADDR_W-1:0]   wb_rd,
    input  wire [`RV_XLEN-1:0]         wb_data,
    idex_if.src                        id_out
);

    // x0 has no storage
    logic [`RV_XLEN-1:0]       regs [1:`RV_NUM_REGS-1];

    rv_exec_pkg::opcode_e      opcode;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    rv_exec_pkg::instr_type_e  instr_type;
    rv_exec_pkg::alu_op_e      alu_op;
    logic [`RV_XLEN-1:0]       imm;
    logic                      alu_src;
    logic                      mem_read;
    logic                      mem_write;
    logic                      branch_inst;
    logic                      writes_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign opcode = rv_exec_pkg::opcode_e'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];

    // Format and control; anything unknown looks like a bubble
    always_comb begin
        instr_type  = rv_exec_pkg::TYPE_R;
        alu_op      = rv_exec_pkg::ALU_ADD;
        alu_src     = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch_inst = 1'b0;
        writes_rd   = 1'b0;
        case (opcode)
            rv_exec_pkg::OPC_OP: begin
                alu_op    = rv_exec_pkg::ALU_REG;
                writes_rd = 1'b1;
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                instr_type = rv_exec_pkg::TYPE_I;
                alu_op     = rv_exec_pkg::ALU_IMM;
                alu_src    = 1'b1;
                writes_rd  = 1'b1;
            end
            rv_exec_pkg::OPC_LOAD: begin
                instr_type = rv_exec_pkg::TYPE_I;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                writes_rd  = 1'b1;
            end
            rv_exec_pkg::OPC_STORE: begin
                instr_type = rv_exec_pkg::TYPE_S;
                alu_src    = 1'b1;
                mem_write  = 1'b1;
            end
            rv_exec_pkg::OPC_BRANCH: begin
                instr_type  = rv_exec_pkg::TYPE_B;
                alu_op      = rv_exec_pkg::ALU_BRANCH;
                branch_inst = 1'b1;
            end
            rv_exec_pkg::OPC_LUI: begin
                instr_type = rv_exec_pkg::TYPE_U;
                alu_op     = rv_exec_pkg::ALU_LUI;
                alu_src    = 1'b1;
                writes_rd  = 1'b1;
            end
            rv_exec_pkg::OPC_AUIPC: begin
                instr_type = rv_exec_pkg::TYPE_U;
                alu_src    = 1'b1;
                writes_rd  = 1'b1;
            end
            default: ;
        endcase
    end

    // Immediates, sign-extended from bit 31
    always_comb begin
        case (instr_type)
            rv_exec_pkg::TYPE_I: imm = {{20{instruction[31]}}, instruction[31:20]};
            rv_exec_pkg::TYPE_S: imm = {{20{instruction[31]}}, instruction[31:25],
                                        instruction[11:7]};
            rv_exec_pkg::TYPE_B: imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                                        instruction[30:25], instruction[11:8], 1'b0};
            rv_exec_pkg::TYPE_U: imm = {instruction[31:12], 12'b0};
            default:             imm = '0;
        endcase
    end

    assign id_out.instruction  = instruction;
    assign id_out.pc           = pc;
    assign id_out.immediate    = imm;
    assign id_out.rs1          = rs1;
    assign id_out.rs2          = rs2;
    assign id_out.data_rs1     = (rs1 == '0) ? '0 : regs[rs1];
    assign id_out.data_rs2     = (rs2 == '0) ? '0 : regs[rs2];
    assign id_out.alu_src      = alu_src;
    assign id_out.alu_op       = alu_op;
    assign id_out.funct7       = instruction[31:25];
    assign id_out.funct3       = instruction[14:12];
    assign id_out.opcode       = opcode;
    assign id_out.instr_type   = instr_type;
    assign id_out.rd           = rd;
    assign id_out.mem_write    = mem_write;
    assign id_out.mem_read     = mem_read;
    assign id_out.branch_inst  = branch_inst;
    assign id_out.mem_to_reg   = mem_read;
    assign id_out.write_enable = writes_rd && (rd != '0);

endmodule

`default_nettype wire

//--- rtl/idex_if.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

interface idex_if;

    logic [`RV_XLEN-1:0]        instruction;
    logic [`RV_XLEN-1:0]        pc;
    logic [`RV_XLEN-1:0]        immediate;
    logic [`RV_REG_ADDR_W-1:0]  rs1;
    logic [`RV_REG_ADDR_W-1:0]  rs2;
    logic [`RV_XLEN-1:0]        data_rs1;
    logic [`RV_XLEN-1:0]        data_rs2;

    // ALU controls
    logic                       alu_src;
    rv_exec_pkg::alu_op_e       alu_op;
    logic [6:0]                 funct7;
    logic [2:0]                 funct3;
    rv_exec_pkg::opcode_e       opcode;
    rv_exec_pkg::instr_type_e   instr_type;

    // Passed along to later stages
    logic [`RV_REG_ADDR_W-1:0]  rd;
    logic                       mem_write;
    logic                       mem_read;
    logic                       branch_inst;
    logic                       mem_to_reg;
    logic                       write_enable;

    modport src (
        output instruction, pc, immediate, rs1, rs2, data_rs1, data_rs2,
        output alu_src, alu_op, funct7, funct3, opcode, instr_type,
        output rd, mem_write, mem_read, branch_inst, mem_to_reg, write_enable
    );

    modport dst (
        input instruction, pc, immediate, rs1, rs2, data_rs1, data_rs2,
        input alu_src, alu_op, funct7, funct3, opcode, instr_type,
        input rd, mem_write, mem_read, branch_inst, mem_to_reg, write_enable
    );

endinterface

`default_nettype wire

//--- rtl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // Operation class handed to execute
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_REG    = 3'd1,
        ALU_IMM    = 3'd2,
        ALU_BRANCH = 3'd3,
        ALU_LUI    = 3'd4
    } alu_op_e;

    typedef enum logic [2:0] {
        TYPE_R = 3'd0,
        TYPE_I = 3'd1,
        TYPE_S = 3'd2,
        TYPE_B = 3'd3,
        TYPE_U = 3'd4
    } instr_type_e;

    // funct3 for OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    // funct3 for BRANCH
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_f3_e;

endpackage

`default_nettype wire

//--- rtl/rv_exec_consts.svh
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// Data and address width
`define RV_XLEN 32

// Register index width
`define RV_REG_ADDR_W 5

// Architectural register count, x0 included
`define RV_NUM_REGS 32

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif
